// File: id_pkg.sv
package id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           inst_t;

    // major opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;

    // special function field, inst[5:0]
    localparam logic [5:0] FUNC_OR   = 6'b100101;
    localparam logic [5:0] FUNC_AND  = 6'b100100;
    localparam logic [5:0] FUNC_XOR  = 6'b100110;
    localparam logic [5:0] FUNC_NOR  = 6'b100111;
    localparam logic [5:0] FUNC_SLL  = 6'b000000;
    localparam logic [5:0] FUNC_SRL  = 6'b000010;
    localparam logic [5:0] FUNC_SRA  = 6'b000011;
    localparam logic [5:0] FUNC_SLLV = 6'b000100;
    localparam logic [5:0] FUNC_SRLV = 6'b000110;
    localparam logic [5:0] FUNC_SRAV = 6'b000111;
    localparam logic [5:0] FUNC_SLT  = 6'b101010;
    localparam logic [5:0] FUNC_SLTU = 6'b101011;
    localparam logic [5:0] FUNC_ADD  = 6'b100000;
    localparam logic [5:0] FUNC_ADDU = 6'b100001;
    localparam logic [5:0] FUNC_SUB  = 6'b100010;
    localparam logic [5:0] FUNC_SUBU = 6'b100011;
    localparam logic [5:0] FUNC_MOVN = 6'b001011;
    localparam logic [5:0] FUNC_MOVZ = 6'b001010;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_OR    = 8'b0010_0101,
        ALU_AND   = 8'b0010_0100,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLL   = 8'b0111_1100,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_MOVN  = 8'b0000_1011,
        ALU_MOVZ  = 8'b0000_1010
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alusel_e;

    typedef enum logic [1:0] {
        MOVE_ALWAYS     = 2'd0,
        MOVE_IF_NONZERO = 2'd1,
        MOVE_IF_ZERO    = 2'd2
    } move_cond_e;

    // write port as seen by the decode stage
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        data_t     data;
    } wr_port_t;

    typedef struct packed {
        aluop_e     aluop;
        alusel_e    alusel;
        move_cond_e move_cond;
        logic       wreg;
        reg_addr_t  wd;
        logic       reg1_read;
        logic       reg2_read;
        reg_addr_t  reg1_addr;
        reg_addr_t  reg2_addr;
        data_t      imm;
        logic       illegal;
    } decode_t;

    typedef struct packed {
        logic      valid;
        aluop_e    aluop;
        alusel_e   alusel;
        data_t     reg1;
        data_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        logic      illegal;
    } ex_pkt_t;

endpackage

// File: regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic              clk,
    input  logic              arst_n_i,
    input  id_pkg::wr_port_t  wb_i,
    input  id_pkg::reg_addr_t raddr1_i,
    input  id_pkg::reg_addr_t raddr2_i,
    output id_pkg::data_t     rdata1_o,
    output id_pkg::data_t     rdata2_o
);
    import id_pkg::*;

    data_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = wb_i.we && (wb_i.addr != '0);  // r0 is never written

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // same-cycle write-back is passed straight through
    assign rdata1_o = (raddr1_i == '0)                   ? '0 :
                      (wr_en && wb_i.addr == raddr1_i) ? wb_i.data : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                   ? '0 :
                      (wr_en && wb_i.addr == raddr2_i) ? wb_i.data : regs[raddr2_i];

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  id_pkg::inst_t   inst_i,
    output id_pkg::decode_t dec_o
);
    import id_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    reg_addr_t  shamt;
    data_t      zext_imm;
    data_t      sext_imm;
    data_t      lui_imm;

    // special table lookup
    logic       r_hit;
    logic       r_shamt_form;
    logic       r_fields_ok;
    aluop_e     r_op;
    alusel_e    r_sel;
    move_cond_e r_cond;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];

    assign zext_imm = {16'h0, inst_i[15:0]};
    assign sext_imm = {{16{inst_i[15]}}, inst_i[15:0]};
    assign lui_imm  = {inst_i[15:0], 16'h0};

    // immediate forms read rs, write rt
    function automatic decode_t imm_form(input aluop_e op, input alusel_e sel,
                                         input data_t imm, input reg_addr_t src,
                                         input reg_addr_t dst);
        decode_t d;
        d           = '0;
        d.aluop     = op;
        d.alusel    = sel;
        d.move_cond = MOVE_ALWAYS;
        d.wreg      = 1'b1;
        d.wd        = dst;
        d.reg1_read = 1'b1;
        d.reg1_addr = src;
        d.reg2_addr = dst;
        d.imm       = imm;
        return d;
    endfunction

    always_comb begin
        r_hit        = 1'b1;
        r_shamt_form = 1'b0;
        r_sel        = SEL_LOGIC;
        r_cond       = MOVE_ALWAYS;
        r_op         = ALU_NOP;
        case (funct)
            FUNC_OR:   r_op = ALU_OR;
            FUNC_AND:  r_op = ALU_AND;
            FUNC_XOR:  r_op = ALU_XOR;
            FUNC_NOR:  r_op = ALU_NOR;
            FUNC_SLL, FUNC_SRL, FUNC_SRA: begin
                r_shamt_form = 1'b1;
                r_sel        = SEL_SHIFT;
                r_op         = (funct == FUNC_SLL) ? ALU_SLL :
                               (funct == FUNC_SRL) ? ALU_SRL : ALU_SRA;
            end
            FUNC_SLLV, FUNC_SRLV, FUNC_SRAV: begin
                r_sel = SEL_SHIFT;
                r_op  = (funct == FUNC_SLLV) ? ALU_SLL :
                        (funct == FUNC_SRLV) ? ALU_SRL : ALU_SRA;
            end
            FUNC_SLT, FUNC_SLTU, FUNC_ADD, FUNC_ADDU, FUNC_SUB, FUNC_SUBU: begin
                r_sel = SEL_ARITH;
                case (funct)
                    FUNC_SLT:  r_op = ALU_SLT;
                    FUNC_SLTU: r_op = ALU_SLTU;
                    FUNC_ADD:  r_op = ALU_ADD;
                    FUNC_ADDU: r_op = ALU_ADDU;
                    FUNC_SUB:  r_op = ALU_SUB;
                    default:   r_op = ALU_SUBU;
                endcase
            end
            FUNC_MOVN: begin
                r_sel  = SEL_MOVE;
                r_op   = ALU_MOVN;
                r_cond = MOVE_IF_NONZERO;
            end
            FUNC_MOVZ: begin
                r_sel  = SEL_MOVE;
                r_op   = ALU_MOVZ;
                r_cond = MOVE_IF_ZERO;
            end
            default:   r_hit = 1'b0;
        endcase
    end

    // shamt shifts need rs zero, the rest need shamt zero
    assign r_fields_ok = r_shamt_form ? (rs == '0) : (shamt == '0);

    always_comb begin
        dec_o.aluop     = ALU_NOP;
        dec_o.alusel    = SEL_NOP;
        dec_o.move_cond = MOVE_ALWAYS;
        dec_o.wreg      = 1'b0;
        dec_o.wd        = rd;
        dec_o.reg1_read = 1'b0;
        dec_o.reg2_read = 1'b0;
        dec_o.reg1_addr = rs;
        dec_o.reg2_addr = rt;
        dec_o.imm       = '0;
        dec_o.illegal   = 1'b1;  // cleared below on a known encoding
        case (opcode)
            OP_SPECIAL: begin
                if (r_hit && r_fields_ok) begin
                    dec_o.aluop     = r_op;
                    dec_o.alusel    = r_sel;
                    dec_o.move_cond = r_cond;
                    dec_o.wreg      = 1'b1;
                    dec_o.reg1_read = !r_shamt_form;  // operand 1 is shamt
                    dec_o.reg2_read = 1'b1;
                    dec_o.imm       = r_shamt_form ? {{(DATA_W-REG_ADDR_W){1'b0}}, shamt} : '0;
                    dec_o.illegal   = 1'b0;
                end
            end
            OP_ORI:   dec_o = imm_form(ALU_OR, SEL_LOGIC, zext_imm, rs, rt);
            OP_ANDI:  dec_o = imm_form(ALU_AND, SEL_LOGIC, zext_imm, rs, rt);
            OP_XORI:  dec_o = imm_form(ALU_XOR, SEL_LOGIC, zext_imm, rs, rt);
            OP_LUI:   dec_o = imm_form(ALU_OR, SEL_LOGIC, lui_imm, rs, rt);
            OP_SLTI:  dec_o = imm_form(ALU_SLT, SEL_ARITH, sext_imm, rs, rt);
            OP_SLTIU: dec_o = imm_form(ALU_SLTU, SEL_ARITH, sext_imm, rs, rt);
            OP_ADDI:  dec_o = imm_form(ALU_ADDI, SEL_ARITH, sext_imm, rs, rt);
            OP_ADDIU: dec_o = imm_form(ALU_ADDIU, SEL_ARITH, sext_imm, rs, rt);
            default: begin
            end
        endcase
    end

endmodule

// File: operand_forward.sv
`timescale 1ns/1ns

module operand_forward (
    input  logic              read_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::data_t     imm_i,
    input  id_pkg::data_t     rf_data_i,
    input  id_pkg::wr_port_t  ex_fwd_i,
    input  id_pkg::wr_port_t  mem_fwd_i,
    output id_pkg::data_t     opnd_o
);

    // youngest producer wins
    always_comb begin
        if (!read_i) begin
            opnd_o = imm_i;
        end else if (addr_i == '0) begin
            opnd_o = '0;
        end else if (ex_fwd_i.we && ex_fwd_i.addr == addr_i) begin
            opnd_o = ex_fwd_i.data;
        end else if (mem_fwd_i.we && mem_fwd_i.addr == addr_i) begin
            opnd_o = mem_fwd_i.data;
        end else begin
            opnd_o = rf_data_i;  // includes wb write-through
        end
    end

endmodule

// File: id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            valid_i,
    input  id_pkg::decode_t dec_i,
    input  id_pkg::data_t   opnd1_i,
    input  id_pkg::data_t   opnd2_i,
    output id_pkg::ex_pkt_t pkt_o
);
    import id_pkg::*;

    logic      wreg_fin;
    logic      valid_q;
    aluop_e    aluop_q;
    alusel_e   alusel_q;
    logic      wreg_q;
    logic      illegal_q;
    data_t     reg1_q;
    data_t     reg2_q;
    reg_addr_t wd_q;

    // movn/movz decide on the forwarded rt value
    always_comb begin
        case (dec_i.move_cond)
            MOVE_IF_NONZERO: wreg_fin = dec_i.wreg && (opnd2_i != '0);
            MOVE_IF_ZERO:    wreg_fin = dec_i.wreg && (opnd2_i == '0);
            default:         wreg_fin = dec_i.wreg;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q   <= 1'b0;
            aluop_q   <= ALU_NOP;
            alusel_q  <= SEL_NOP;
            wreg_q    <= 1'b0;
            illegal_q <= 1'b0;
        end else if (valid_i) begin
            valid_q   <= 1'b1;
            aluop_q   <= dec_i.aluop;
            alusel_q  <= dec_i.alusel;
            wreg_q    <= wreg_fin;
            illegal_q <= dec_i.illegal;
        end else begin
            valid_q   <= 1'b0;  // bubble
            aluop_q   <= ALU_NOP;
            alusel_q  <= SEL_NOP;
            wreg_q    <= 1'b0;
            illegal_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        reg1_q <= opnd1_i;
        reg2_q <= opnd2_i;
        wd_q   <= dec_i.wd;
    end

    assign pkt_o = '{valid:   valid_q,
                     aluop:   aluop_q,
                     alusel:  alusel_q,
                     reg1:    reg1_q,
                     reg2:    reg2_q,
                     wd:      wd_q,
                     wreg:    wreg_q,
                     illegal: illegal_q};

endmodule

// File: id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             inst_valid_i,
    input  id_pkg::inst_t    inst_i,
    input  id_pkg::wr_port_t ex_fwd_i,
    input  id_pkg::wr_port_t mem_fwd_i,
    input  id_pkg::wr_port_t wb_i,
    output id_pkg::ex_pkt_t  ex_pkt_o
);
    import id_pkg::*;

    decode_t dec;
    data_t   rf_rdata1;
    data_t   rf_rdata2;
    data_t   opnd1;
    data_t   opnd2;

    regfile regfile_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (wb_i),
        .raddr1_i (dec.reg1_addr),
        .raddr2_i (dec.reg2_addr),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    inst_decoder inst_decoder_i (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    operand_forward fwd1_i (
        .read_i    (dec.reg1_read),
        .addr_i    (dec.reg1_addr),
        .imm_i     (dec.imm),
        .rf_data_i (rf_rdata1),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .opnd_o    (opnd1)
    );

    operand_forward fwd2_i (
        .read_i    (dec.reg2_read),
        .addr_i    (dec.reg2_addr),
        .imm_i     (dec.imm),
        .rf_data_i (rf_rdata2),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .opnd_o    (opnd2)
    );

    id_ex_reg id_ex_reg_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (inst_valid_i),
        .dec_i    (dec),
        .opnd1_i  (opnd1),
        .opnd2_i  (opnd2),
        .pkt_o    (ex_pkt_o)
    );

endmodule

// File: tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;
    import id_pkg::*;

    localparam string VEC_FILE = "id_vectors.txt";

    // one cycle of stimulus plus the packet expected from the previous cycle
    typedef struct packed {
        logic       valid;
        inst_t      inst;
        wr_port_t   ex_fwd;
        wr_port_t   mem_fwd;
        wr_port_t   wb;
        logic [1:0] chk;  // 0 skip, 1 control fields, 2 all fields
        ex_pkt_t    exp;
    } vec_t;

    logic     clk;
    logic     arst_n;
    logic     inst_valid;
    inst_t    inst;
    wr_port_t ex_fwd;
    wr_port_t mem_fwd;
    wr_port_t wb;
    ex_pkt_t  ex_pkt;

    vec_t vecs[$];
    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   cycle_limit = 20;

    id_stage id_stage_i (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .ex_fwd_i     (ex_fwd),
        .mem_fwd_i    (mem_fwd),
        .wb_i         (wb),
        .ex_pkt_o     (ex_pkt)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic cmp_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic cmp_aluop(input string name, input aluop_e exp, input aluop_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic cmp_alusel(input string name, input alusel_e exp, input alusel_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic cmp_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic cmp_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_packet(input logic [1:0] chk, input ex_pkt_t exp);
        if (chk == 2'd0) begin
            return;
        end
        cmp_flag("ex_pkt_o.valid", exp.valid, ex_pkt.valid);
        cmp_aluop("ex_pkt_o.aluop", exp.aluop, ex_pkt.aluop);
        cmp_alusel("ex_pkt_o.alusel", exp.alusel, ex_pkt.alusel);
        cmp_flag("ex_pkt_o.wreg", exp.wreg, ex_pkt.wreg);
        cmp_flag("ex_pkt_o.illegal", exp.illegal, ex_pkt.illegal);
        if (chk == 2'd2) begin
            cmp_data("ex_pkt_o.reg1", exp.reg1, ex_pkt.reg1);
            cmp_data("ex_pkt_o.reg2", exp.reg2, ex_pkt.reg2);
            cmp_addr("ex_pkt_o.wd", exp.wd, ex_pkt.wd);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        vec_t        v;
        logic [31:0] f [20];
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the vector file %s", VEC_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;  // blank or column notes
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
            if (n != 20) begin
                errors++;
                $display("vector line has %0d fields instead of 20: %s", n, line);
                continue;
            end
            v.valid        = f[0][0];
            v.inst         = f[1];
            v.ex_fwd       = '{we: f[2][0], addr: f[3][4:0], data: f[4]};
            v.mem_fwd      = '{we: f[5][0], addr: f[6][4:0], data: f[7]};
            v.wb           = '{we: f[8][0], addr: f[9][4:0], data: f[10]};
            v.chk          = f[11][1:0];
            v.exp.valid    = f[12][0];
            v.exp.aluop    = aluop_e'(f[13][7:0]);
            v.exp.alusel   = alusel_e'(f[14][2:0]);
            v.exp.reg1     = f[15];
            v.exp.reg2     = f[16];
            v.exp.wd       = f[17][4:0];
            v.exp.wreg     = f[18][0];
            v.exp.illegal  = f[19][0];
            vecs.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input vec_t v);
        inst_valid = v.valid;
        inst       = v.inst;
        ex_fwd     = v.ex_fwd;
        mem_fwd    = v.mem_fwd;
        wb         = v.wb;
    endtask

    initial begin
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb         = '0;
        load_vectors();
        cycle_limit = 2 * vecs.size() + 20;
        repeat (4) begin
            @(negedge clk);
            check_packet(2'd1, '0);  // control fields held clear in reset
        end
        arst_n = 1'b1;
        // packet seen here belongs to the line before
        foreach (vecs[i]) begin
            check_packet(vecs[i].chk, vecs[i].exp);
            apply_vector(vecs[i]);
            @(negedge clk);
        end
        $display("errors %0d, checks %0d, vectors %0d", errors, checks, vecs.size());
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, the vectors did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

// File: id_vectors.txt
# valid inst | ex we addr data | mem we addr data | wb we addr data
# chk (0 skip, 1 ctrl, 2 all) | prev packet: valid aluop alusel reg1 reg2 wd wreg illegal
0 00000000 0 00 00000000 0 00 00000000 1 01 12345678 1 0 00 0 00000000 00000000 00 0 0
0 00000000 0 00 00000000 0 00 00000000 1 02 000000f0 1 0 00 0 00000000 00000000 00 0 0
0 00000000 0 00 00000000 0 00 00000000 1 03 80000001 1 0 00 0 00000000 00000000 00 0 0
0 00000000 0 00 00000000 0 00 00000000 1 00 deadbeef 1 0 00 0 00000000 00000000 00 0 0
0 00000000 0 00 00000000 0 00 00000000 1 05 00000004 1 0 00 0 00000000 00000000 00 0 0
1 00222025 0 00 00000000 0 00 00000000 0 00 00000000 1 0 00 0 00000000 00000000 00 0 0
1 00233024 0 00 00000000 0 00 00000000 0 00 00000000 2 1 25 1 12345678 000000f0 04 1 0
1 00023827 0 00 00000000 0 00 00000000 0 00 00000000 2 1 24 1 12345678 80000001 06 1 0
1 00a14004 0 00 00000000 0 00 00000000 0 00 00000000 2 1 27 1 00000000 000000f0 07 1 0
1 00a34807 0 00 00000000 0 00 00000000 0 00 00000000 2 1 7c 2 00000004 12345678 08 1 0
1 0061502a 0 00 00000000 0 00 00000000 0 00 00000000 2 1 03 2 00000004 80000001 09 1 0
1 00405822 0 00 00000000 0 00 00000000 0 00 00000000 2 1 2a 4 80000001 12345678 0a 1 0
1 0022602b 0 00 00000000 0 00 00000000 0 00 00000000 2 1 22 4 000000f0 00000000 0b 1 0
1 344d8001 0 00 00000000 0 00 00000000 0 00 00000000 2 1 2b 4 12345678 000000f0 0c 1 0
1 302eff00 0 00 00000000 0 00 00000000 0 00 00000000 2 1 25 1 000000f0 00008001 0d 1 0
1 386fa5a5 0 00 00000000 0 00 00000000 0 00 00000000 2 1 24 1 12345678 0000ff00 0e 1 0
1 3c10beef 0 00 00000000 0 00 00000000 0 00 00000000 2 1 26 1 80000001 0000a5a5 0f 1 0
1 2831fffe 0 00 00000000 0 00 00000000 0 00 00000000 2 1 25 1 00000000 beef0000 10 1 0
1 2c528000 0 00 00000000 0 00 00000000 0 00 00000000 2 1 2a 4 12345678 fffffffe 11 1 0
1 20737fff 0 00 00000000 0 00 00000000 0 00 00000000 2 1 2b 4 000000f0 ffff8000 12 1 0
1 24b49000 0 00 00000000 0 00 00000000 0 00 00000000 2 1 55 4 80000001 00007fff 13 1 0
1 0001a900 0 00 00000000 0 00 00000000 0 00 00000000 2 1 56 4 00000004 ffff9000 14 1 0
1 0003b7c3 0 00 00000000 0 00 00000000 0 00 00000000 2 1 7c 2 00000004 12345678 15 1 0
1 0002b842 0 00 00000000 0 00 00000000 0 00 00000000 2 1 03 2 0000001f 80000001 16 1 0
1 00c7c021 1 06 11111111 1 06 22222222 1 07 33333333 2 1 02 2 00000001 000000f0 17 1 0
1 00c7c021 0 06 11111111 1 06 22222222 1 06 44444444 2 1 21 4 11111111 33333333 18 1 0
1 00c7c021 1 07 55555555 1 07 66666666 0 00 00000000 2 1 21 4 22222222 33333333 18 1 0
1 0007c021 1 00 77777777 1 07 88888888 1 00 99999999 2 1 21 4 44444444 55555555 18 1 0
1 0020c80b 0 00 00000000 0 00 00000000 0 00 00000000 2 1 21 4 00000000 88888888 18 1 0
1 0022c80b 0 00 00000000 0 00 00000000 0 00 00000000 2 1 0b 3 12345678 00000000 19 0 0
1 0026d00a 1 06 00000000 0 00 00000000 0 00 00000000 2 1 0b 3 12345678 000000f0 19 1 0
1 0026d00a 1 06 00000001 0 00 00000000 0 00 00000000 2 1 0a 3 12345678 00000000 1a 1 0
1 fc000000 0 00 00000000 0 00 00000000 0 00 00000000 2 1 0a 3 12345678 00000001 1a 0 0
1 0022203f 0 00 00000000 0 00 00000000 0 00 00000000 1 1 00 0 00000000 00000000 00 0 1
0 00222025 0 00 00000000 0 00 00000000 0 00 00000000 1 1 00 0 00000000 00000000 00 0 1
0 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 0 00 0 00000000 00000000 00 0 0

// File: files.f
id_pkg.sv
regfile.sv
inst_decoder.sv
operand_forward.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
